// ==== rtl/rv32_isa_pkg.sv ====
package rv32_isa_pkg;

    // width of a destination register index.
    localparam int REG_IDX_W = 5;

    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // access width of a load or store.
    typedef enum logic [1:0] {
        MEM_WORD = 2'b00,
        MEM_HALF = 2'b01,
        MEM_BYTE = 2'b10
    } mem_width_t;

    // branch condition, evaluated against the ALU result.
    typedef enum logic [1:0] {
        BR_NEVER   = 2'b00,
        BR_ZERO    = 2'b01, // taken when the result is zero.
        BR_NONZERO = 2'b10, // taken when the result is non-zero.
        BR_ALWAYS  = 2'b11
    } branch_op_t;

endpackage

// ==== rtl/rv32_bus_pkg.sv ====
package rv32_bus_pkg;

    localparam int XLEN = 32;
    localparam int BYTE_LANES = XLEN / 8;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [XLEN-1:0] addr_t;

    // bit 3 enables the lane in bits 31:24.
    typedef logic [BYTE_LANES-1:0] byte_mask_t;

    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW = $clog2(DMEM_WORDS); // word index width.

endpackage

// ==== rtl/rv32_branch_unit.sv ====
`timescale 1ns/1ps

module rv32_branch_unit (
    input  rv32_isa_pkg::branch_op_t op,
    input  rv32_bus_pkg::word_t      result,
    output logic                     taken
);
    import rv32_isa_pkg::*;
    import rv32_bus_pkg::*;

    logic result_zero;

    assign result_zero = (result == {XLEN{1'b0}}); // the ALU does the compare, we only test it.

    always_comb begin
        case (op)
            BR_NEVER:   taken = 1'b0;
            BR_ZERO:    taken = result_zero;
            BR_NONZERO: taken = !result_zero;
            BR_ALWAYS:  taken = 1'b1;
            default:    taken = 1'b0;
        endcase
    end

endmodule

// ==== rtl/rv32_mem_stage.sv ====
`timescale 1ns/1ps

module rv32_mem_stage (
    input  logic                     clk,
    input  logic                     arst_n,

    input  logic                     stall,
    input  logic                     flush,

    input  logic                     read,
    input  logic                     write,
    input  logic                     zero_extend,
    input  rv32_isa_pkg::mem_width_t width,
    input  rv32_isa_pkg::branch_op_t branch_op,
    input  rv32_isa_pkg::reg_idx_t   rd_in,
    input  logic                     rd_write_in,

    input  rv32_bus_pkg::word_t      result,
    input  rv32_bus_pkg::word_t      rs2_value,
    input  rv32_bus_pkg::word_t      branch_pc_in,

    input  rv32_bus_pkg::word_t      data_read_value,

    output logic                     branch_taken,
    output rv32_isa_pkg::reg_idx_t   rd,
    output logic                     rd_write,
    output rv32_bus_pkg::word_t      rd_value,
    output rv32_bus_pkg::word_t      branch_pc,

    output logic                     data_read,
    output rv32_bus_pkg::byte_mask_t data_write_mask,
    output rv32_bus_pkg::addr_t      data_address,
    output rv32_bus_pkg::word_t      data_write_value
);
    import rv32_isa_pkg::*;
    import rv32_bus_pkg::*;

    logic       store_en;
    byte_mask_t lane_mask;
    logic [7:0] load_byte;
    logic [15:0] load_half;
    word_t      load_value;

    rv32_branch_unit branch_unit (
        .op     (branch_op),
        .result (result),
        .taken  (branch_taken)
    );

    assign branch_pc = branch_pc_in;

    assign data_read    = read;
    assign data_address = result;

    // a stalled or squashed instruction must not touch memory.
    assign store_en = write && !stall && !flush;

    // store data goes to the addressed lane, unused lanes read as zero.
    always_comb begin
        data_write_value = '0;
        lane_mask        = '0;
        case (width)
            MEM_WORD: begin
                data_write_value = rs2_value;
                lane_mask        = 4'b1111;
            end
            MEM_HALF: begin
                if (!result[0]) begin
                    data_write_value = {rs2_value[15:0], 16'h0000};
                    lane_mask        = 4'b1100;
                end else begin
                    data_write_value = {16'h0000, rs2_value[15:0]};
                    lane_mask        = 4'b0011;
                end
            end
            MEM_BYTE: begin
                case (result[1:0])
                    2'b00: data_write_value = {rs2_value[7:0], 24'h000000};
                    2'b01: data_write_value = {8'h00, rs2_value[7:0], 16'h0000};
                    2'b10: data_write_value = {16'h0000, rs2_value[7:0], 8'h00};
                    default: data_write_value = {24'h000000, rs2_value[7:0]};
                endcase
                lane_mask = 4'b1000 >> result[1:0]; // offset k lands in lane 3-k.
            end
            default: begin
                data_write_value = '0;
                lane_mask        = '0;
            end
        endcase
    end

    assign data_write_mask = store_en ? lane_mask : '0;

    // offset 0 is the most significant lane.
    always_comb begin
        case (result[1:0])
            2'b00:   load_byte = data_read_value[31:24];
            2'b01:   load_byte = data_read_value[23:16];
            2'b10:   load_byte = data_read_value[15:8];
            default: load_byte = data_read_value[7:0];
        endcase
        load_half = result[0] ? data_read_value[15:0] : data_read_value[31:16];
    end

    always_comb begin
        case (width)
            MEM_WORD: load_value = data_read_value;
            MEM_HALF: load_value = {{16{!zero_extend && load_half[15]}}, load_half};
            MEM_BYTE: load_value = {{24{!zero_extend && load_byte[7]}}, load_byte};
            default:  load_value = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd       <= '0;
            rd_write <= 1'b0;
            rd_value <= '0;
        end else if (!stall) begin
            rd       <= rd_in;
            rd_write <= rd_write_in && !flush; // flush wins over the write enable.
            rd_value <= read ? load_value : result;
        end
    end

endmodule

// ==== rtl/rv32_data_ram.sv ====
`timescale 1ns/1ps

module rv32_data_ram (
    input  logic                     clk,
    input  rv32_bus_pkg::addr_t      address,
    output rv32_bus_pkg::word_t      read_value,
    input  rv32_bus_pkg::byte_mask_t write_mask,
    input  rv32_bus_pkg::word_t      write_value
);
    import rv32_bus_pkg::*;

    word_t              mem [DMEM_WORDS];
    logic [DMEM_AW-1:0] word_idx;

    // byte offset bits are dropped and the index wraps at DMEM_WORDS.
    assign word_idx = address[DMEM_AW+1:2];

    assign read_value = mem[word_idx]; // combinational read for the load path.

    always_ff @(posedge clk) begin
        for (int lane = 0; lane < BYTE_LANES; lane++) begin
            if (write_mask[lane]) begin
                mem[word_idx][lane*8 +: 8] <= write_value[lane*8 +: 8];
            end
        end
    end

endmodule

// ==== rtl/rv32_mem_subsystem.sv ====
`timescale 1ns/1ps

module rv32_mem_subsystem (
    input  logic                     clk,
    input  logic                     arst_n,

    input  logic                     stall,
    input  logic                     flush,

    input  logic                     read,
    input  logic                     write,
    input  logic                     zero_extend,
    input  rv32_isa_pkg::mem_width_t width,
    input  rv32_isa_pkg::branch_op_t branch_op,
    input  rv32_isa_pkg::reg_idx_t   rd_in,
    input  logic                     rd_write_in,

    input  rv32_bus_pkg::word_t      result,
    input  rv32_bus_pkg::word_t      rs2_value,
    input  rv32_bus_pkg::word_t      branch_pc_in,

    output logic                     branch_taken,
    output rv32_isa_pkg::reg_idx_t   rd,
    output logic                     rd_write,
    output rv32_bus_pkg::word_t      rd_value,
    output rv32_bus_pkg::word_t      branch_pc,

    // bus signals kept visible for observation.
    output logic                     data_read,
    output rv32_bus_pkg::addr_t      data_address
);
    import rv32_bus_pkg::*;

    word_t      data_read_value;
    byte_mask_t data_write_mask;
    word_t      data_write_value;

    rv32_mem_stage mem_stage (
        .clk              (clk),
        .arst_n           (arst_n),
        .stall            (stall),
        .flush            (flush),
        .read             (read),
        .write            (write),
        .zero_extend      (zero_extend),
        .width            (width),
        .branch_op        (branch_op),
        .rd_in            (rd_in),
        .rd_write_in      (rd_write_in),
        .result           (result),
        .rs2_value        (rs2_value),
        .branch_pc_in     (branch_pc_in),
        .data_read_value  (data_read_value),
        .branch_taken     (branch_taken),
        .rd               (rd),
        .rd_write         (rd_write),
        .rd_value         (rd_value),
        .branch_pc        (branch_pc),
        .data_read        (data_read),
        .data_write_mask  (data_write_mask),
        .data_address     (data_address),
        .data_write_value (data_write_value)
    );

    rv32_data_ram data_ram (
        .clk         (clk),
        .address     (data_address),
        .read_value  (data_read_value),
        .write_mask  (data_write_mask),
        .write_value (data_write_value)
    );

endmodule

// ==== verif/rv32_mem_tb.sv ====
`timescale 1ns/1ps

module rv32_mem_tb;
    import rv32_isa_pkg::*;
    import rv32_bus_pkg::*;

    localparam int    CLK_PERIOD   = 40;
    localparam int    RESET_CYCLES = 8;
    localparam int    FIELDS       = 18; // columns per line of the golden file.
    localparam int    MAX_VECTORS  = 128;
    localparam string GOLDEN_FILE  = "verif/rv32_mem_golden.txt";

    logic       clk;
    logic       arst_n;
    logic       stall;
    logic       flush;
    logic       read;
    logic       write;
    logic       zero_extend;
    mem_width_t width;
    branch_op_t branch_op;
    reg_idx_t   rd_in;
    logic       rd_write_in;
    word_t      result;
    word_t      rs2_value;
    word_t      branch_pc_in;

    logic       branch_taken;
    reg_idx_t   rd;
    logic       rd_write;
    word_t      rd_value;
    word_t      branch_pc;
    logic       data_read;
    addr_t      data_address;

    logic [31:0] golden [MAX_VECTORS*FIELDS];
    int          num_vectors;
    int          test_errors;
    int          pass_count;
    int          fail_count;
    integer      seed;
    bit          vectors_loaded;

    rv32_mem_subsystem DUT (
        .clk          (clk),
        .arst_n       (arst_n),
        .stall        (stall),
        .flush        (flush),
        .read         (read),
        .write        (write),
        .zero_extend  (zero_extend),
        .width        (width),
        .branch_op    (branch_op),
        .rd_in        (rd_in),
        .rd_write_in  (rd_write_in),
        .result       (result),
        .rs2_value    (rs2_value),
        .branch_pc_in (branch_pc_in),
        .branch_taken (branch_taken),
        .rd           (rd),
        .rd_write     (rd_write),
        .rd_value     (rd_value),
        .branch_pc    (branch_pc),
        .data_read    (data_read),
        .data_address (data_address)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("Error: %s expected %h, got %h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_mask(input string name, input byte_mask_t expected,
                              input byte_mask_t actual);
        if (actual !== expected) begin
            $display("Error: %s expected %h, got %h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t expected, input reg_idx_t actual);
        if (actual !== expected) begin
            $display("Error: %s expected %h, got %h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error: %s expected %h, got %h", name, expected, actual);
            test_errors++;
        end
    endtask

    function automatic int test_number_of(input int idx);
        return golden[idx*FIELDS];
    endfunction

    // an idle slot reads, writes and retires nothing.
    task automatic drive_idle();
        stall        = 1'b0;
        flush        = 1'b0;
        read         = 1'b0;
        write        = 1'b0;
        zero_extend  = 1'b0;
        width        = MEM_WORD;
        branch_op    = BR_NEVER;
        rd_in        = '0;
        rd_write_in  = 1'b0;
        result       = $random(seed);
        rs2_value    = '0;
        branch_pc_in = '0;
    endtask

    task automatic apply_vector(input int idx);
        int base;
        base = idx * FIELDS;
        stall        = golden[base+1][0];
        flush        = golden[base+2][0];
        read         = golden[base+3][0];
        write        = golden[base+4][0];
        width        = mem_width_t'(golden[base+5][1:0]);
        zero_extend  = golden[base+6][0];
        branch_op    = branch_op_t'(golden[base+7][1:0]);
        rd_in        = golden[base+8][REG_IDX_W-1:0];
        rd_write_in  = golden[base+9][0];
        result       = golden[base+10];
        rs2_value    = golden[base+11];
        branch_pc_in = golden[base+12];
    endtask

    // outputs that follow the inputs within the same cycle.
    task automatic check_comb(input int idx);
        int base;
        base = idx * FIELDS;
        check_bit("branch_taken", golden[base+13][0], branch_taken);
        check_mask("data_write_mask", golden[base+14][BYTE_LANES-1:0], DUT.data_write_mask);
        check_word("branch_pc", branch_pc_in, branch_pc);
        check_bit("data_read", read, data_read);
        check_word("data_address", result, data_address);
    endtask

    task automatic check_regs(input int idx);
        int base;
        base = idx * FIELDS;
        check_reg("rd", golden[base+15][REG_IDX_W-1:0], rd);
        check_bit("rd_write", golden[base+16][0], rd_write);
        check_word("rd_value", golden[base+17], rd_value);
    endtask

    task automatic report_test(input int num);
        if (test_errors == 0) begin
            $display("test %0d passed", num);
            pass_count++;
        end else begin
            $display("test %0d failed with %0d mismatches", num, test_errors);
            fail_count++;
        end
        test_errors = 0;
    endtask

    initial begin
        int fillers;
        clk         = 1'b0;
        arst_n      = 1'b0;
        seed        = 32'hd898;
        test_errors = 0;
        pass_count  = 0;
        fail_count  = 0;
        num_vectors = 0;
        drive_idle();
        rd_write_in = 1'b1; // a pending write-back that reset has to clear.
        rd_in       = '1;

        for (int i = 0; i < MAX_VECTORS*FIELDS; i++) begin
            golden[i] = '1; // an all-ones test number marks the end of the vectors.
        end
        $readmemh(GOLDEN_FILE, golden);
        while (num_vectors < MAX_VECTORS && golden[num_vectors*FIELDS] !== 32'hffff_ffff) begin
            num_vectors++;
        end
        vectors_loaded = 1'b1;

        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        check_bit("rd_write", 1'b0, rd_write);
        check_reg("rd", '0, rd);
        check_word("rd_value", '0, rd_value);
        report_test(0);
        drive_idle();

        if (num_vectors == 0) begin
            $display("no vectors could be read from %s", GOLDEN_FILE);
            fail_count++;
        end

        for (int idx = 0; idx < num_vectors; idx++) begin
            @(negedge clk);
            if (idx > 0) begin
                check_regs(idx - 1);
            end
            if (idx > 0 && test_number_of(idx) != test_number_of(idx - 1)) begin
                report_test(test_number_of(idx - 1));
                fillers = {$random(seed)} % 2;
                repeat (fillers) begin
                    drive_idle();
                    @(negedge clk);
                end
            end
            apply_vector(idx);
            #(CLK_PERIOD/4);
            check_comb(idx);
        end

        if (num_vectors > 0) begin
            @(negedge clk);
            check_regs(num_vectors - 1);
            report_test(test_number_of(num_vectors - 1));
        end

        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        wait (vectors_loaded);
        #((num_vectors + 20) * CLK_PERIOD);
        $display("the run timed out after %0d clock cycles", num_vectors + 20);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== verif/rv32_mem_golden.txt ====
// test stall flush read write width zext br_op rd rd_wr result rs2 branch_pc
// expected: taken mask rd rd_wr rd_value (width 0 word, 1 half, 2 byte)
// word store and load back
1 0 0 0 1 0 0 0 00 0 00000040 cafef00d 00001000 0 f 00 0 00000040
1 0 0 1 0 0 0 0 05 1 00000040 00000000 00001004 0 0 05 1 cafef00d
// byte stores to every offset, then halfword stores into both halves
2 0 0 0 1 2 0 0 00 0 00000080 abcdef11 00001008 0 8 00 0 00000080
2 0 0 0 1 2 0 0 00 0 00000081 12345622 0000100c 0 4 00 0 00000081
2 0 0 0 1 2 0 0 00 0 00000082 00000033 00001010 0 2 00 0 00000082
2 0 0 0 1 2 0 0 00 0 00000083 99999944 00001014 0 1 00 0 00000083
2 0 0 1 0 0 0 0 07 1 00000080 00000000 00001018 0 0 07 1 11223344
2 0 0 0 1 1 0 0 00 0 00000081 1234beef 0000101c 0 3 00 0 00000081
2 0 0 1 0 0 0 0 08 1 00000080 00000000 00001020 0 0 08 1 1122beef
2 0 0 0 1 1 0 0 00 0 00000080 0000cafe 00001024 0 c 00 0 00000080
2 0 0 1 0 0 0 0 09 1 00000080 00000000 00001028 0 0 09 1 cafebeef
// sign and zero extension of byte and halfword loads
3 0 0 0 1 0 0 0 00 0 000000c0 81f293c4 00001100 0 f 00 0 000000c0
3 0 0 1 0 2 0 0 0a 1 000000c0 00000000 00001104 0 0 0a 1 ffffff81
3 0 0 1 0 2 0 0 0b 1 000000c1 00000000 00001108 0 0 0b 1 fffffff2
3 0 0 1 0 2 0 0 0c 1 000000c2 00000000 0000110c 0 0 0c 1 ffffff93
3 0 0 1 0 2 0 0 0d 1 000000c3 00000000 00001110 0 0 0d 1 ffffffc4
3 0 0 1 0 2 1 0 0e 1 000000c0 00000000 00001114 0 0 0e 1 00000081
3 0 0 1 0 2 1 0 0f 1 000000c1 00000000 00001118 0 0 0f 1 000000f2
3 0 0 1 0 2 1 0 10 1 000000c2 00000000 0000111c 0 0 10 1 00000093
3 0 0 1 0 2 1 0 11 1 000000c3 00000000 00001120 0 0 11 1 000000c4
3 0 0 1 0 1 0 0 12 1 000000c0 00000000 00001124 0 0 12 1 ffff81f2
3 0 0 1 0 1 0 0 13 1 000000c1 00000000 00001128 0 0 13 1 ffff93c4
3 0 0 1 0 1 1 0 14 1 000000c0 00000000 0000112c 0 0 14 1 000081f2
3 0 0 1 0 1 1 0 15 1 000000c1 00000000 00001130 0 0 15 1 000093c4
// ALU result passes through when nothing is read
4 0 0 0 0 0 0 0 03 1 12345678 00000000 00002000 0 0 03 1 12345678
4 0 0 0 0 0 0 0 1f 0 deadbeef 00000000 00002004 0 0 1f 0 deadbeef
4 0 0 0 0 2 1 0 06 1 ffffff80 00000000 00002008 0 0 06 1 ffffff80
// stall holds the write-back register, flush squashes, neither one stores
5 0 0 0 0 0 0 0 04 1 0000aaaa 00000000 00003000 0 0 04 1 0000aaaa
5 1 0 0 1 0 0 0 09 0 00000040 55555555 00003004 0 0 04 1 0000aaaa
5 1 0 0 0 0 0 0 0a 1 77777777 00000000 00003008 0 0 04 1 0000aaaa
5 0 0 1 0 0 0 0 0b 1 00000040 00000000 0000300c 0 0 0b 1 cafef00d
5 0 1 0 1 0 0 0 0c 1 00000040 66666666 00003010 0 0 0c 0 00000040
5 0 1 1 0 0 0 0 0d 1 00000040 00000000 00003014 0 0 0d 0 cafef00d
5 0 0 1 0 0 0 0 0e 1 00000040 00000000 00003018 0 0 0e 1 cafef00d
5 1 1 0 1 0 0 0 0f 1 00000040 12121212 0000301c 0 0 0e 1 cafef00d
5 0 0 1 0 0 0 0 10 1 00000040 00000000 00003020 0 0 10 1 cafef00d
// branch conditions with zero and non-zero results
6 0 0 0 0 0 0 0 00 0 00000000 00000000 00004000 0 0 00 0 00000000
6 0 0 0 0 0 0 0 00 0 00000005 00000000 00004004 0 0 00 0 00000005
6 0 0 0 0 0 0 1 00 0 00000000 00000000 00004008 1 0 00 0 00000000
6 0 0 0 0 0 0 1 00 0 00000005 00000000 0000400c 0 0 00 0 00000005
6 0 0 0 0 0 0 2 00 0 00000000 00000000 00004010 0 0 00 0 00000000
6 0 0 0 0 0 0 2 00 0 80000000 00000000 00004014 1 0 00 0 80000000
6 0 0 0 0 0 0 3 00 0 00000000 00000000 00004018 1 0 00 0 00000000
6 0 0 0 0 0 0 3 00 0 00000005 00000000 0000401c 1 0 00 0 00000005

// ==== project.f ====
rtl/rv32_isa_pkg.sv
rtl/rv32_bus_pkg.sv
rtl/rv32_branch_unit.sv
rtl/rv32_mem_stage.sv
rtl/rv32_data_ram.sv
rtl/rv32_mem_subsystem.sv
verif/rv32_mem_tb.sv

// ==== Makefile ====
TOOL      := verilator
FLAGS     := --binary --timing --timescale 1ns/1ps
TOP       := rv32_mem_tb
FILELIST  := project.f

BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
GOLDEN    := verif/rv32_mem_golden.txt
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes.
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN) $(GOLDEN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
